// File: src/lockstep_pkg.sv
// Lockstep offsets, multibit flag codes, core command and result types
package lockstep_pkg;

  //////////////////////////////////////////////////////////////////////
  // Lockstep timing
  //////////////////////////////////////////////////////////////////////

  // Cycles the shadow core lags the main core
  localparam int unsigned LOCKSTEP_OFFSET = 2;
  // Extra cycle for the shadow output register
  localparam int unsigned OUTPUTS_OFFSET = LOCKSTEP_OFFSET + 1;
  // Reset sequencing counter width, at least one bit
  localparam int unsigned CNT_W = (LOCKSTEP_OFFSET > 1) ? $clog2(LOCKSTEP_OFFSET) : 1;

  //////////////////////////////////////////////////////////////////////
  // Core datapath widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ACC_W     = 32;
  localparam int unsigned OPND_W    = 16;
  localparam int unsigned CNT_OUT_W = 8;

  // Multibit flag, only two of the sixteen codes are legal
  localparam int unsigned MUBI_W = 4;
  typedef logic [MUBI_W-1:0] mubi_t;
  localparam mubi_t MUBI_ON  = 4'b0110;
  localparam mubi_t MUBI_OFF = 4'b1001;

  typedef enum logic [1:0] {
    OP_CLEAR = 2'd0,
    OP_LOAD  = 2'd1,
    OP_ADD   = 2'd2,
    OP_XOR   = 2'd3
  } acc_op_e;

  // Everything the core consumes
  typedef struct packed {
    logic              valid;
    acc_op_e           op;
    logic [OPND_W-1:0] operand;
  } core_in_t;

  // Everything the core produces, compared as one word
  typedef struct packed {
    logic                 valid;
    logic [ACC_W-1:0]     acc;
    logic [CNT_OUT_W-1:0] count;
  } core_out_t;

endpackage

// File: src/acc_core.sv
// Accumulator core executing clear, load, add and xor commands
`timescale 1ns/100ps

module acc_core (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  lockstep_pkg::core_in_t  cmd_i,
  output lockstep_pkg::core_out_t result_o
);

  import lockstep_pkg::*;

  logic [ACC_W-1:0]     operand_ext;
  logic [ACC_W-1:0]     acc_d;
  logic [ACC_W-1:0]     acc_q;
  logic [CNT_OUT_W-1:0] count_d;
  logic [CNT_OUT_W-1:0] count_q;
  logic                 valid_q;

  // Operand is unsigned, upper bits zero
  assign operand_ext = ACC_W'(cmd_i.operand);

  //////////////////////////////////////////////////////////////////////
  // Command decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    acc_d   = acc_q;
    count_d = count_q;
    if (cmd_i.valid) begin
      unique case (cmd_i.op)
        OP_CLEAR: acc_d = '0;
        OP_LOAD:  acc_d = operand_ext;
        // Wraps modulo 2^32
        OP_ADD:   acc_d = acc_q + operand_ext;
        OP_XOR:   acc_d = acc_q ^ operand_ext;
      endcase
      // Count wraps at 256
      count_d = count_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State and result registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      acc_q   <= '0;
      count_q <= '0;
      valid_q <= 1'b0;
    end else begin
      acc_q   <= acc_d;
      count_q <= count_d;
      valid_q <= cmd_i.valid;
    end
  end

  // Result reflects the previous cycle's command
  assign result_o.valid = valid_q;
  assign result_o.acc   = acc_q;
  assign result_o.count = count_q;

endmodule

// File: src/shadow_reset_ctrl.sv
// Shadow core reset sequencing and lockstep comparison enable
`timescale 1ns/100ps

module shadow_reset_ctrl (
  input  logic                clk_i,
  input  logic                reset_i,
  output logic                shadow_reset_o,
  output lockstep_pkg::mubi_t cmp_enable_o
);

  import lockstep_pkg::*;

  logic [CNT_W-1:0] cnt_q;
  logic             cnt_done;
  mubi_t            released_d;
  mubi_t            released_q;
  mubi_t            cmp_enable_q;

  //////////////////////////////////////////////////////////////////////
  // Release counter
  //////////////////////////////////////////////////////////////////////

  // Starts on system reset and stops at the last lag cycle
  assign cnt_done = (cnt_q == CNT_W'(LOCKSTEP_OFFSET - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (!cnt_done) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Multibit flags
  //////////////////////////////////////////////////////////////////////

  assign released_d = cnt_done ? MUBI_ON : MUBI_OFF;

  // Enable follows the release flag one cycle later
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      released_q   <= MUBI_OFF;
      cmp_enable_q <= MUBI_OFF;
    end else begin
      released_q   <= released_d;
      cmp_enable_q <= released_q;
    end
  end

  // Bit 0 is set in MUBI_OFF and clear in MUBI_ON
  assign shadow_reset_o = released_q[0];

  // A corrupted code anywhere but MUBI_OFF leaves the comparison on
  assign cmp_enable_o = cmp_enable_q;

endmodule

// File: src/shadow_channel.sv
// Shadow input delay line, shadow core and shadow output register
`timescale 1ns/100ps

module shadow_channel (
  input  logic                    clk_i,
  input  logic                    shadow_reset_i,
  input  lockstep_pkg::core_in_t  cmd_i,
  output lockstep_pkg::core_out_t shadow_out_o
);

  import lockstep_pkg::*;

  // Entry LOCKSTEP_OFFSET-1 takes the live command, entry 0 feeds the core
  core_in_t [LOCKSTEP_OFFSET-1:0] cmd_dly_q;
  core_out_t                      shadow_out_d;
  core_out_t                      shadow_out_q;

  //////////////////////////////////////////////////////////////////////
  // Input delay line
  //////////////////////////////////////////////////////////////////////

  // Held clear while the shadow core is in reset
  always_ff @(posedge clk_i) begin
    if (shadow_reset_i) begin
      cmd_dly_q <= '0;
    end else begin
      for (int unsigned i = 0; i < LOCKSTEP_OFFSET - 1; i++) begin
        cmd_dly_q[i] <= cmd_dly_q[i+1];
      end
      cmd_dly_q[LOCKSTEP_OFFSET-1] <= cmd_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Shadow core
  //////////////////////////////////////////////////////////////////////

  acc_core u_shadow_core (
    .clk_i    (clk_i),
    .reset_i  (shadow_reset_i),
    .cmd_i    (cmd_dly_q[0]),
    .result_o (shadow_out_d)
  );

  // Extra stage, absorbed by OUTPUTS_OFFSET on the main side
  always_ff @(posedge clk_i) begin
    shadow_out_q <= shadow_out_d;
  end

  assign shadow_out_o = shadow_out_q;

endmodule

// File: src/output_comparator.sv
// Main output delay line, fault injection and lockstep output compare
`timescale 1ns/100ps

module output_comparator (
  input  logic                    clk_i,
  input  lockstep_pkg::core_out_t main_out_i,
  input  lockstep_pkg::core_out_t shadow_out_i,
  input  lockstep_pkg::mubi_t     cmp_enable_i,
  input  logic                    fault_inject_i,
  output logic                    alert_major_o
);

  import lockstep_pkg::*;

  core_out_t                     main_inj;
  core_out_t [OUTPUTS_OFFSET-1:0] main_dly_q;
  logic                          outputs_differ;

  //////////////////////////////////////////////////////////////////////
  // Fault injection
  //////////////////////////////////////////////////////////////////////

  // Only the compared copy is touched, result_o stays clean
  always_comb begin
    main_inj        = main_out_i;
    main_inj.acc[0] = main_out_i.acc[0] ^ fault_inject_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Output delay line
  //////////////////////////////////////////////////////////////////////

  // Lines the main word up with the registered shadow word
  always_ff @(posedge clk_i) begin
    for (int unsigned i = 0; i < OUTPUTS_OFFSET - 1; i++) begin
      main_dly_q[i] <= main_dly_q[i+1];
    end
    main_dly_q[OUTPUTS_OFFSET-1] <= main_inj;
  end

  //////////////////////////////////////////////////////////////////////
  // Compare
  //////////////////////////////////////////////////////////////////////

  // Whole struct, valid and count included
  assign outputs_differ = (main_dly_q[0] != shadow_out_i);

  // Blocked only by an exact MUBI_OFF
  assign alert_major_o = (cmp_enable_i != MUBI_OFF) & outputs_differ;

endmodule

// File: src/lockstep_top.sv
// Dual-core lockstep top level with main core and shadow comparison
`timescale 1ns/100ps

module lockstep_top (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  lockstep_pkg::core_in_t  cmd_i,
  input  logic                    fault_inject_i,
  output lockstep_pkg::core_out_t result_o,
  output logic                    alert_major_o
);

  import lockstep_pkg::*;

  logic      shadow_reset;
  mubi_t     cmp_enable;
  core_out_t shadow_out;

  //////////////////////////////////////////////////////////////////////
  // Main core
  //////////////////////////////////////////////////////////////////////

  // Runs on the live commands, drives the result directly
  acc_core u_main_core (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .cmd_i    (cmd_i),
    .result_o (result_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Lockstep stages
  //////////////////////////////////////////////////////////////////////

  shadow_reset_ctrl u_shadow_reset_ctrl (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .shadow_reset_o (shadow_reset),
    .cmp_enable_o   (cmp_enable)
  );

  // Same commands, LOCKSTEP_OFFSET cycles later
  shadow_channel u_shadow_channel (
    .clk_i          (clk_i),
    .shadow_reset_i (shadow_reset),
    .cmd_i          (cmd_i),
    .shadow_out_o   (shadow_out)
  );

  output_comparator u_output_comparator (
    .clk_i          (clk_i),
    .main_out_i     (result_o),
    .shadow_out_i   (shadow_out),
    .cmp_enable_i   (cmp_enable),
    .fault_inject_i (fault_inject_i),
    .alert_major_o  (alert_major_o)
  );

endmodule

// File: testbench/lockstep_checker.sv
// Concurrent assertions on lockstep alert timing and fault injection
`timescale 1ns/100ps

module lockstep_checker (
  input logic clk_i,
  input logic reset_i,
  input logic fault_inject_i,
  input logic alert_major_i
);

  import lockstep_pkg::*;

  int unsigned               cycle_q;
  logic [OUTPUTS_OFFSET-1:0] fault_hist_q;
  logic                      fault_held_q;
  logic                      comparing;
  logic                      held_now;
  int                        quiet_fails = 0;
  int                        held_fails  = 0;
  int                        track_fails = 0;
  int                        error_count;

  //////////////////////////////////////////////////////////////////////
  // Expected alert timing
  //////////////////////////////////////////////////////////////////////

  // Cycle index since reset release, stops once comparing
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cycle_q      <= 0;
      fault_hist_q <= '0;
      fault_held_q <= 1'b1;
    end else begin
      if (cycle_q <= LOCKSTEP_OFFSET) begin
        cycle_q <= cycle_q + 1;
      end
      // Newest injection enters at bit 0
      fault_hist_q <= {fault_hist_q[OUTPUTS_OFFSET-2:0], fault_inject_i};
      fault_held_q <= fault_held_q & fault_inject_i;
    end
  end

  assign comparing   = (cycle_q > LOCKSTEP_OFFSET);
  assign held_now    = fault_held_q & fault_inject_i;
  assign error_count = quiet_fails + held_fails + track_fails;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Shadow in reset or comparison not yet enabled
  quiet_before_enable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !comparing |-> !alert_major_i
  ) else begin
    quiet_fails = quiet_fails + 1;
    $error("alert_major_o went high at %0d ns before the comparison was enabled", $time);
  end

  held_fault_alerts: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (comparing && held_now) |-> alert_major_i
  ) else begin
    held_fails = held_fails + 1;
    $error("alert_major_o low at %0d ns with the fault held since reset release", $time);
  end

  // High exactly OUTPUTS_OFFSET cycles after each injection, low otherwise
  alert_tracks_injection: assert property (
    @(posedge clk_i) disable iff (reset_i)
    comparing |-> (alert_major_i == fault_hist_q[OUTPUTS_OFFSET-1])
  ) else begin
    track_fails = track_fails + 1;
    $error("** Error at %0d ns: alert_major_o expected %b, got %b",
           $time, fault_hist_q[OUTPUTS_OFFSET-1], alert_major_i);
  end

endmodule

// File: testbench/lockstep_tb.sv
// Lockstep testbench with clock, reset, random commands, accumulator model and report
`timescale 1ns/100ps

module lockstep_tb;

  import lockstep_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int HOLD_CYCLES  = 12;
  localparam int RANDOM_CMDS  = 200;
  localparam int PULSES       = 8;
  localparam int MAX_GAP      = 8;
  // Summed test lengths plus margin
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + HOLD_CYCLES + RANDOM_CMDS
                                   + PULSES * (OUTPUTS_OFFSET + MAX_GAP + 1)
                                   + 2 * (OUTPUTS_OFFSET + 2) + 50;

  logic      clk_i;
  logic      reset_i;
  core_in_t  cmd_i;
  logic      fault_inject_i;
  core_out_t result_o;
  logic      alert_major_o;

  core_out_t exp_out       = '0;
  int        since_release = 0;
  int        tb_errors     = 0;
  int        checks        = 0;
  int        seed          = 32'h25f6;

  lockstep_top dut0 (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .cmd_i          (cmd_i),
    .fault_inject_i (fault_inject_i),
    .result_o       (result_o),
    .alert_major_o  (alert_major_o)
  );

  bind lockstep_top lockstep_checker u_checker (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fault_inject_i (fault_inject_i),
    .alert_major_i  (alert_major_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Accumulator model and result check
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (reset_i) begin
      exp_out       = '0;
      since_release = 0;
    end else begin
      if (since_release < 2) begin
        since_release = since_release + 1;
      end
      if (cmd_i.valid) begin
        case (cmd_i.op)
          OP_CLEAR: exp_out.acc = '0;
          OP_LOAD:  exp_out.acc = {{(ACC_W-OPND_W){1'b0}}, cmd_i.operand};
          OP_ADD:   exp_out.acc = exp_out.acc + {{(ACC_W-OPND_W){1'b0}}, cmd_i.operand};
          OP_XOR:   exp_out.acc = exp_out.acc ^ {{(ACC_W-OPND_W){1'b0}}, cmd_i.operand};
        endcase
        exp_out.count = exp_out.count + 8'd1;
      end
      exp_out.valid = cmd_i.valid;
    end
  end

  task automatic check_value(input string name, input logic [ACC_W-1:0] expected,
                             input logic [ACC_W-1:0] actual);
    checks = checks + 1;
    assert (actual === expected)
    else begin
      tb_errors = tb_errors + 1;
      $display("** Error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  // Outputs settle after the rising edge, so sample on the falling one
  always @(negedge clk_i) begin
    check_value("result_o.valid", ACC_W'(exp_out.valid), ACC_W'(result_o.valid));
    check_value("result_o.acc", exp_out.acc, result_o.acc);
    check_value("result_o.count", ACC_W'(exp_out.count), ACC_W'(result_o.count));
    // Reset and the first cycle after it
    if (since_release <= 1) begin
      check_value("alert_major_o", '0, ACC_W'(alert_major_o));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus and reporting
  //////////////////////////////////////////////////////////////////////

  task automatic drive_random_command();
    logic [31:0] rnd;
    rnd = $random(seed);
    // Roughly three commands in four are valid
    cmd_i.valid   = (rnd[1:0] != 2'b00);
    cmd_i.op      = acc_op_e'(rnd[3:2]);
    cmd_i.operand = rnd[31:16];
  endtask

  function automatic int total_errors();
    return tb_errors + dut0.u_checker.error_count;
  endfunction

  task automatic report_test(input string name, input int errors_before);
    $display("%s: %0d errors", name, total_errors() - errors_before);
  endtask

  initial begin
    int          errors_before;
    int          gap;
    int          i;
    logic [31:0] rnd;
    reset_i        = 1'b1;
    cmd_i          = '0;
    fault_inject_i = 1'b0;

    errors_before = total_errors();
    repeat (RESET_CYCLES - OUTPUTS_OFFSET) @(negedge clk_i);
    // Corrupted words fill the main delay line before release
    fault_inject_i = 1'b1;
    repeat (OUTPUTS_OFFSET) @(negedge clk_i);
    report_test("Test 1 reset", errors_before);

    // Fault stays high across reset release
    errors_before  = total_errors();
    reset_i        = 1'b0;
    repeat (HOLD_CYCLES) @(negedge clk_i);
    fault_inject_i = 1'b0;
    repeat (OUTPUTS_OFFSET + 2) @(negedge clk_i);
    report_test("Test 2 fault held from reset release", errors_before);

    errors_before = total_errors();
    for (i = 0; i < RANDOM_CMDS; i++) begin
      drive_random_command();
      // First four commands walk through every operation
      if (i < 4) begin
        cmd_i.valid = 1'b1;
        cmd_i.op    = acc_op_e'(i[1:0]);
      end
      @(negedge clk_i);
    end
    report_test("Test 3 random commands without injection", errors_before);

    errors_before = total_errors();
    for (i = 0; i < PULSES; i++) begin
      rnd = $random(seed);
      gap = OUTPUTS_OFFSET + 1 + 32'(rnd[2:0]);
      repeat (gap) begin
        drive_random_command();
        @(negedge clk_i);
      end
      fault_inject_i = 1'b1;
      drive_random_command();
      @(negedge clk_i);
      fault_inject_i = 1'b0;
    end
    cmd_i = '0;
    repeat (OUTPUTS_OFFSET + 2) @(negedge clk_i);
    report_test("Test 4 isolated injection pulses", errors_before);

    $display("Totals: 4 tests, %0d value checks, %0d testbench errors, %0d assertion errors",
             checks, tb_errors, dut0.u_checker.error_count);
    if (total_errors() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: files.f
src/lockstep_pkg.sv
src/acc_core.sv
src/shadow_reset_ctrl.sv
src/shadow_channel.sv
src/output_comparator.sv
src/lockstep_top.sv
testbench/lockstep_checker.sv
testbench/lockstep_tb.sv

// File: run.sh
#!/bin/sh
# Compile the lockstep testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lockstep_tb -f files.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Compilation failed with status $status"
  exit 1
fi

# Keep running after an assertion error so the testbench can report
output=$(./obj_dir/Vlockstep_tb +verilator+error+limit+1000 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
  exit 0
fi
echo "Simulation reported failures"
exit 1
